//--- verilog/dispatch_consts.svh
`ifndef DISPATCH_CONSTS_SVH
`define DISPATCH_CONSTS_SVH

// bus widths
`define DISP_ADDR_W 32
`define DISP_DATA_W 32
`define DISP_MSG_W 8
// polled cpu index word, flags on top
`define DISP_IDX_W 16

// cpu slots and counter width, counters must hold DISP_CPU_COUNT
`define DISP_CPU_COUNT 4
`define DISP_CNT_W 3

// cpu to dispatcher message codes
`define MSG_NONE 8'h00
`define MSG_RESET 8'h01
`define MSG_START 8'h02
`define MSG_END 8'h03

// flag bits inside the index word
`define IDX_ACTIVE_BIT 15
`define IDX_FREE_BIT 14

`endif

//--- verilog/dispatch_pkg.sv
`include "dispatch_consts.svh"

package dispatch_pkg;

  // bus words
  typedef logic [`DISP_ADDR_W-1:0] addr_t;
  typedef logic [`DISP_DATA_W-1:0] data_t;
  typedef logic [`DISP_MSG_W-1:0] cpu_msg_t;

  // index word on the cpu bus, flags plus cpu number in low bits
  typedef logic [`DISP_IDX_W-1:0] cpu_idx_t;

  // active / free cpu counters
  typedef logic [`DISP_CNT_W-1:0] cpu_cnt_t;

  // dispatcher controller states
  typedef enum logic [1:0] {
    ST_RESET_WAIT,
    ST_CPU_LOOP,
    ST_CPU_CMD,
    ST_MEM_WORK
  } ctl_state_t;

  // one memory request, rd or wr high marks the issue cycle
  typedef struct packed {
    logic  rd;
    logic  wr;
    addr_t addr;
    data_t data;
  } mem_req_t;

  // memory answer, also the reply handed back to the cpu
  typedef struct packed {
    logic  rd_dn;
    logic  wr_dn;
    addr_t addr;
    data_t data;
  } mem_rsp_t;

endpackage

//--- verilog/dispatch_ctl.sv
`include "dispatch_consts.svh"

module dispatch_ctl (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   read_q,
  input  logic                   write_q,
  input  logic                   ext_cpu_e,
  input  logic                   ext_rst_e,
  input  dispatch_pkg::addr_t    addr_in,
  input  dispatch_pkg::data_t    data_in,
  input  dispatch_pkg::cpu_msg_t cpu_msg_in,
  input  dispatch_pkg::cpu_idx_t pool_idx,
  input  dispatch_pkg::mem_rsp_t mem_done,
  output logic                   poll_step,
  output logic                   cpu_msg_e,
  output logic                   ext_cpu_q,
  output logic                   ext_rst_b,
  output dispatch_pkg::mem_req_t mem_req,
  output dispatch_pkg::cpu_idx_t ext_cpu_index
);

  dispatch_pkg::ctl_state_t state;
  // counts reset reports while cpus come up
  dispatch_pkg::cpu_idx_t   rst_cnt;
  logic                     in_cmd;
  logic                     take_rd;
  logic                     take_wr;
  logic                     take_msg;
  logic                     mem_fin;

  // command priority: read, then write, then message
  assign in_cmd   = (state == dispatch_pkg::ST_CPU_CMD);
  assign take_rd  = in_cmd && read_q;
  assign take_wr  = in_cmd && !read_q && write_q;
  assign take_msg = in_cmd && !read_q && !write_q && ext_cpu_e;
  assign mem_fin  = mem_done.rd_dn || mem_done.wr_dn;

  // loop state lasts one cycle, so this is a single pulse
  assign poll_step = (state == dispatch_pkg::ST_CPU_LOOP);
  assign cpu_msg_e = take_msg;

  // reset-wait counter shown until polling starts
  assign ext_cpu_index = (state == dispatch_pkg::ST_RESET_WAIT) ? rst_cnt : pool_idx;

  // issue strobe, payload zero when idle
  always_comb begin
    mem_req    = '0;
    mem_req.rd = take_rd;
    mem_req.wr = take_wr;
    if (take_rd || take_wr) begin
      mem_req.addr = addr_in;
    end
    // only a write carries data
    if (take_wr) begin
      mem_req.data = data_in;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= dispatch_pkg::ST_RESET_WAIT;
      rst_cnt   <= '0;
      ext_rst_b <= 1'b1;
      ext_cpu_q <= 1'b0;
    end else begin
      // cpu reset released once we are out of rst
      ext_rst_b <= 1'b0;
      // poll strobe follows the loop state by one edge
      ext_cpu_q <= poll_step;
      case (state)
        dispatch_pkg::ST_RESET_WAIT: begin
          if (ext_rst_e) begin
            rst_cnt <= '0;
            state   <= dispatch_pkg::ST_CPU_LOOP;
          end else if (cpu_msg_in == `MSG_RESET) begin
            rst_cnt <= rst_cnt + dispatch_pkg::cpu_idx_t'(1);
          end
        end
        dispatch_pkg::ST_CPU_LOOP: begin
          state <= dispatch_pkg::ST_CPU_CMD;
        end
        dispatch_pkg::ST_CPU_CMD: begin
          // hold here until the polled cpu asks for something
          if (take_rd || take_wr) begin
            state <= dispatch_pkg::ST_MEM_WORK;
          end else if (take_msg) begin
            state <= dispatch_pkg::ST_CPU_LOOP;
          end
        end
        dispatch_pkg::ST_MEM_WORK: begin
          // slow memory just stretches this state
          if (mem_fin) begin
            state <= dispatch_pkg::ST_CPU_LOOP;
          end
        end
        default: begin
          state <= dispatch_pkg::ST_RESET_WAIT;
        end
      endcase
    end
  end

endmodule

//--- verilog/cpu_pool.sv
`include "dispatch_consts.svh"

module cpu_pool (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   poll_step,
  input  logic                   cpu_msg_e,
  input  dispatch_pkg::cpu_msg_t cpu_msg_in,
  output dispatch_pkg::cpu_idx_t pool_idx
);

  dispatch_pkg::cpu_cnt_t act_cnt;
  dispatch_pkg::cpu_cnt_t free_cnt;
  // last polled active cpu number
  dispatch_pkg::cpu_cnt_t cur_num;
  dispatch_pkg::cpu_cnt_t next_num;
  // free slot already offered in this round
  logic                   restarted;
  dispatch_pkg::cpu_idx_t free_idx;
  dispatch_pkg::cpu_idx_t act_idx;

  always_comb begin
    // round robin, wrap past the last active cpu
    if (cur_num >= act_cnt - dispatch_pkg::cpu_cnt_t'(1)) begin
      next_num = '0;
    end else begin
      next_num = cur_num + dispatch_pkg::cpu_cnt_t'(1);
    end
    // free slot offer, number is always zero
    free_idx                = '0;
    free_idx[`IDX_FREE_BIT] = 1'b1;
    act_idx                     = '0;
    act_idx[`IDX_ACTIVE_BIT]    = 1'b1;
    act_idx[`DISP_CNT_W-1:0]    = next_num;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      act_cnt   <= '0;
      free_cnt  <= dispatch_pkg::cpu_cnt_t'(`DISP_CPU_COUNT);
      cur_num   <= '0;
      restarted <= 1'b0;
      pool_idx  <= '0;
    end else begin
      if (poll_step) begin
        if (free_cnt != '0 && !restarted) begin
          pool_idx  <= free_idx;
          restarted <= 1'b1;
        end else if (act_cnt != '0) begin
          cur_num   <= next_num;
          pool_idx  <= act_idx;
          restarted <= 1'b0;
        end else begin
          // nobody active, keep offering the free slot
          pool_idx <= free_idx;
        end
      end
      if (cpu_msg_e) begin
        if (cpu_msg_in == `MSG_START && free_cnt != '0) begin
          act_cnt   <= act_cnt + dispatch_pkg::cpu_cnt_t'(1);
          free_cnt  <= free_cnt - dispatch_pkg::cpu_cnt_t'(1);
          restarted <= 1'b0;
        end else if (cpu_msg_in == `MSG_END && act_cnt != '0) begin
          act_cnt  <= act_cnt - dispatch_pkg::cpu_cnt_t'(1);
          free_cnt <= free_cnt + dispatch_pkg::cpu_cnt_t'(1);
        end
      end
    end
  end

endmodule

//--- verilog/mem_bridge.sv
module mem_bridge (
  input  logic                   clk,
  input  logic                   rst,
  input  dispatch_pkg::mem_req_t mem_req,
  input  logic                   ext_read_dn,
  input  logic                   ext_write_dn,
  input  dispatch_pkg::addr_t    ext_mem_addr_in,
  input  dispatch_pkg::data_t    ext_mem_data_in,
  output logic                   ext_read_q,
  output logic                   ext_write_q,
  output dispatch_pkg::addr_t    ext_mem_addr_out,
  output dispatch_pkg::data_t    ext_mem_data_out,
  output dispatch_pkg::mem_rsp_t mem_done
);

  // outstanding request, rd/wr here mean pending
  dispatch_pkg::mem_req_t pend;
  logic                   issue;
  logic                   pending;
  logic                   rd_hit;
  logic                   wr_hit;

  assign issue   = mem_req.rd || mem_req.wr;
  assign pending = pend.rd || pend.wr;

  // only the done of the pending kind counts
  assign rd_hit = pend.rd && ext_read_dn;
  assign wr_hit = pend.wr && ext_write_dn;

  // bus shows the latched request only while it is outstanding
  assign ext_mem_addr_out = pending ? pend.addr : '0;
  assign ext_mem_data_out = pending ? pend.data : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      pend        <= '0;
      ext_read_q  <= 1'b0;
      ext_write_q <= 1'b0;
      mem_done    <= '0;
    end else begin
      // strobes are one cycle, same step as the latch
      ext_read_q  <= mem_req.rd;
      ext_write_q <= mem_req.wr;
      // reply lives for a single cycle
      mem_done    <= '0;
      if (issue) begin
        pend.rd   <= mem_req.rd;
        pend.wr   <= mem_req.wr;
        pend.addr <= mem_req.addr;
        pend.data <= mem_req.data;
      end else if (rd_hit || wr_hit) begin
        mem_done.rd_dn <= rd_hit;
        mem_done.wr_dn <= wr_hit;
        mem_done.addr  <= ext_mem_addr_in;
        mem_done.data  <= ext_mem_data_in;
        // back to an idle, zeroed bus
        pend <= '0;
      end
    end
  end

endmodule

//--- verilog/cpu_dispatcher.sv
module cpu_dispatcher (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   read_q,
  input  logic                   write_q,
  input  logic                   ext_cpu_e,
  input  logic                   ext_rst_e,
  input  logic                   ext_read_dn,
  input  logic                   ext_write_dn,
  input  dispatch_pkg::addr_t    addr_in,
  input  dispatch_pkg::addr_t    ext_mem_addr_in,
  input  dispatch_pkg::data_t    data_in,
  input  dispatch_pkg::data_t    ext_mem_data_in,
  input  dispatch_pkg::cpu_msg_t cpu_msg_in,
  output logic                   ext_cpu_q,
  output logic                   ext_rst_b,
  output logic                   read_dn,
  output logic                   write_dn,
  output logic                   ext_read_q,
  output logic                   ext_write_q,
  output dispatch_pkg::cpu_idx_t ext_cpu_index,
  output dispatch_pkg::addr_t    addr_out,
  output dispatch_pkg::addr_t    ext_mem_addr_out,
  output dispatch_pkg::data_t    data_out,
  output dispatch_pkg::data_t    ext_mem_data_out
);

  logic                   poll_step;
  logic                   cpu_msg_e;
  dispatch_pkg::cpu_idx_t pool_idx;
  dispatch_pkg::mem_req_t mem_req;
  dispatch_pkg::mem_rsp_t mem_done;
  // memory answer bundled as it arrives
  dispatch_pkg::mem_rsp_t mem_ans;

  assign mem_ans = '{rd_dn: ext_read_dn, wr_dn: ext_write_dn,
                     addr: ext_mem_addr_in, data: ext_mem_data_in};

  // cpu reply unpacked from the bridge result
  assign read_dn  = mem_done.rd_dn;
  assign write_dn = mem_done.wr_dn;
  assign addr_out = mem_done.addr;
  assign data_out = mem_done.data;

  dispatch_ctl i_dispatch_ctl (
    .clk           (clk),
    .rst           (rst),
    .read_q        (read_q),
    .write_q       (write_q),
    .ext_cpu_e     (ext_cpu_e),
    .ext_rst_e     (ext_rst_e),
    .addr_in       (addr_in),
    .data_in       (data_in),
    .cpu_msg_in    (cpu_msg_in),
    .pool_idx      (pool_idx),
    .mem_done      (mem_done),
    .poll_step     (poll_step),
    .cpu_msg_e     (cpu_msg_e),
    .ext_cpu_q     (ext_cpu_q),
    .ext_rst_b     (ext_rst_b),
    .mem_req       (mem_req),
    .ext_cpu_index (ext_cpu_index)
  );

  cpu_pool i_cpu_pool (
    .clk        (clk),
    .rst        (rst),
    .poll_step  (poll_step),
    .cpu_msg_e  (cpu_msg_e),
    .cpu_msg_in (cpu_msg_in),
    .pool_idx   (pool_idx)
  );

  mem_bridge i_mem_bridge (
    .clk              (clk),
    .rst              (rst),
    .mem_req          (mem_req),
    .ext_read_dn      (mem_ans.rd_dn),
    .ext_write_dn     (mem_ans.wr_dn),
    .ext_mem_addr_in  (mem_ans.addr),
    .ext_mem_data_in  (mem_ans.data),
    .ext_read_q       (ext_read_q),
    .ext_write_q      (ext_write_q),
    .ext_mem_addr_out (ext_mem_addr_out),
    .ext_mem_data_out (ext_mem_data_out),
    .mem_done         (mem_done)
  );

endmodule

//--- tb/dispatch_props.sv
module dispatch_props (
  input logic clk,
  input logic rst,
  input logic ext_cpu_q,
  input logic ext_read_q,
  input logic ext_write_q,
  input logic read_dn,
  input logic ext_read_dn,
  input logic ext_rst_b
);
  timeunit 1ns;
  timeprecision 100ps;

  // poll strobe is a single-cycle pulse
  a_poll_pulse: assert property (@(posedge clk) disable iff (rst) ext_cpu_q |=> !ext_cpu_q)
    else $error("ext_cpu_q high in two consecutive cycles");

  // one memory request kind at a time
  a_one_strobe: assert property (@(posedge clk) disable iff (rst) !(ext_read_q && ext_write_q))
    else $error("ext_read_q and ext_write_q high together");

  // cpu read reply only follows a memory read done
  a_read_reply: assert property (@(posedge clk) disable iff (rst) read_dn |-> $past(ext_read_dn))
    else $error("read_dn without ext_read_dn in the previous cycle");

  // cpus released right after reset
  a_rst_release: assert property (@(posedge clk) $fell(rst) |=> !ext_rst_b)
    else $error("ext_rst_b still high one cycle after rst fell");

endmodule

bind cpu_dispatcher dispatch_props i_dispatch_props (
  .clk         (clk),
  .rst         (rst),
  .ext_cpu_q   (ext_cpu_q),
  .ext_read_q  (ext_read_q),
  .ext_write_q (ext_write_q),
  .read_dn     (read_dn),
  .ext_read_dn (ext_read_dn),
  .ext_rst_b   (ext_rst_b)
);

//--- tb/tb_cpu_dispatcher.sv
`include "dispatch_consts.svh"

module tb_cpu_dispatcher;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_CASES = 64;
  // reset reports sent while the cpus come up
  localparam int N_RESETS = 3;

  logic                   clk = 1'b0;
  logic                   rst;
  logic                   read_q;
  logic                   write_q;
  logic                   ext_cpu_e;
  logic                   ext_rst_e;
  logic                   ext_read_dn;
  logic                   ext_write_dn;
  dispatch_pkg::addr_t    addr_in;
  dispatch_pkg::addr_t    ext_mem_addr_in;
  dispatch_pkg::data_t    data_in;
  dispatch_pkg::data_t    ext_mem_data_in;
  dispatch_pkg::cpu_msg_t cpu_msg_in;
  logic                   ext_cpu_q;
  logic                   ext_rst_b;
  logic                   read_dn;
  logic                   write_dn;
  logic                   ext_read_q;
  logic                   ext_write_q;
  dispatch_pkg::cpu_idx_t ext_cpu_index;
  dispatch_pkg::addr_t    addr_out;
  dispatch_pkg::addr_t    ext_mem_addr_out;
  dispatch_pkg::data_t    data_out;
  dispatch_pkg::data_t    ext_mem_data_out;

  // case table from the data file
  string                  case_kind [MAX_CASES];
  dispatch_pkg::addr_t    case_addr [MAX_CASES];
  dispatch_pkg::data_t    case_wdata [MAX_CASES];
  dispatch_pkg::data_t    case_reply [MAX_CASES];
  int                     n_cases;
  logic                   cases_loaded = 1'b0;

  // what the memory model hands back for the current case
  dispatch_pkg::data_t    mem_reply;
  dispatch_pkg::data_t    mem_wdata;
  integer                 seed = 32'h87c39cfa;

  // expected pool state, fed only by messages sent
  int                     model_act;
  int                     model_free;
  int                     model_cur;
  logic                   model_restarted;

  int                     n_value_err;
  int                     n_other_err;

  always #5 clk = ~clk;

  cpu_dispatcher i_cpu_dispatcher (
    .clk              (clk),
    .rst              (rst),
    .read_q           (read_q),
    .write_q          (write_q),
    .ext_cpu_e        (ext_cpu_e),
    .ext_rst_e        (ext_rst_e),
    .ext_read_dn      (ext_read_dn),
    .ext_write_dn     (ext_write_dn),
    .addr_in          (addr_in),
    .ext_mem_addr_in  (ext_mem_addr_in),
    .data_in          (data_in),
    .ext_mem_data_in  (ext_mem_data_in),
    .cpu_msg_in       (cpu_msg_in),
    .ext_cpu_q        (ext_cpu_q),
    .ext_rst_b        (ext_rst_b),
    .read_dn          (read_dn),
    .write_dn         (write_dn),
    .ext_read_q       (ext_read_q),
    .ext_write_q      (ext_write_q),
    .ext_cpu_index    (ext_cpu_index),
    .addr_out         (addr_out),
    .ext_mem_addr_out (ext_mem_addr_out),
    .data_out         (data_out),
    .ext_mem_data_out (ext_mem_data_out)
  );

  task automatic report_mismatch(string what, logic [31:0] got, logic [31:0] exp);
    n_value_err++;
    $display("FAILED %0t: %s is %h, expected %h", $time, what, got, exp);
  endtask

  task automatic report_problem(string what);
    n_other_err++;
    $display("problem at %0t: %s", $time, what);
  endtask

  task automatic load_cases();
    int    fd;
    int    n;
    string line;
    string kind;
    dispatch_pkg::addr_t a;
    dispatch_pkg::data_t w;
    dispatch_pkg::data_t r;
    n_cases = 0;
    fd = $fopen("tb/dispatch_cases.txt", "r");
    if (fd == 0) begin
      report_problem("cannot open the case file tb/dispatch_cases.txt");
    end else begin
      while (!$feof(fd) && n_cases < MAX_CASES) begin
        n = $fgets(line, fd);
        // skip comments and blank lines
        if (n > 0 && line.len() > 2 && line[0] != "#") begin
          n = $sscanf(line, "%s %h %h %h", kind, a, w, r);
          if (n == 4) begin
            case_kind[n_cases]  = kind;
            case_addr[n_cases]  = a;
            case_wdata[n_cases] = w;
            case_reply[n_cases] = r;
            n_cases++;
          end else begin
            report_problem($sformatf("malformed case line: %s", line));
          end
        end
      end
      $fclose(fd);
    end
    if (n_cases == 0) begin
      report_problem("no cases were read from the case file");
    end
  endtask

  // next expected index from the pool rules
  task automatic predict_poll(output dispatch_pkg::cpu_idx_t idx);
    idx = '0;
    if (model_free > 0 && !model_restarted) begin
      idx[`IDX_FREE_BIT] = 1'b1;
      model_restarted    = 1'b1;
    end else if (model_act > 0) begin
      // wrap past the last active cpu
      if (model_cur + 1 >= model_act) begin
        model_cur = 0;
      end else begin
        model_cur = model_cur + 1;
      end
      idx[`IDX_ACTIVE_BIT]   = 1'b1;
      idx[`DISP_CNT_W-1:0]   = model_cur[`DISP_CNT_W-1:0];
      model_restarted        = 1'b0;
    end else begin
      idx[`IDX_FREE_BIT] = 1'b1;
    end
  endtask

  task automatic check_next_poll();
    dispatch_pkg::cpu_idx_t exp_idx;
    @(negedge clk);
    while (ext_cpu_q !== 1'b1) @(negedge clk);
    predict_poll(exp_idx);
    if (ext_cpu_index !== exp_idx) begin
      report_mismatch("poll index", 32'(ext_cpu_index), 32'(exp_idx));
    end
  endtask

  task automatic run_reset_wait();
    @(negedge clk);
    if (ext_rst_b !== 1'b1) begin
      report_mismatch("ext_rst_b during rst", 32'(ext_rst_b), 32'd1);
    end
    repeat (2) @(posedge clk);
    #1;
    rst        = 1'b0;
    cpu_msg_in = `MSG_RESET;
    repeat (N_RESETS) @(posedge clk);
    #1;
    cpu_msg_in = `MSG_NONE;
    @(negedge clk);
    if (ext_cpu_index !== dispatch_pkg::cpu_idx_t'(N_RESETS)) begin
      report_mismatch("reset count", 32'(ext_cpu_index), N_RESETS);
    end
    if (ext_rst_b !== 1'b0) begin
      report_mismatch("ext_rst_b after reset", 32'(ext_rst_b), 32'd0);
    end
    // all strobes idle out of reset
    if ({ext_cpu_q, read_dn, write_dn, ext_read_q, ext_write_q} !== 5'b0) begin
      report_mismatch("idle strobes", 32'({ext_cpu_q, read_dn, write_dn, ext_read_q,
                      ext_write_q}), 32'd0);
    end
    @(posedge clk);
    #1;
    ext_rst_e = 1'b1;
    @(posedge clk);
    #1;
    ext_rst_e = 1'b0;
    @(negedge clk);
    if (ext_cpu_index !== '0) begin
      report_mismatch("index after ext_rst_e", 32'(ext_cpu_index), 32'd0);
    end
  endtask

  task automatic send_message(dispatch_pkg::cpu_msg_t msg);
    @(posedge clk);
    #1;
    ext_cpu_e  = 1'b1;
    cpu_msg_in = msg;
    @(posedge clk);
    #1;
    ext_cpu_e  = 1'b0;
    cpu_msg_in = `MSG_NONE;
    if (msg == `MSG_START && model_free > 0) begin
      model_act++;
      model_free--;
      model_restarted = 1'b0;
    end else if (msg == `MSG_END && model_act > 0) begin
      model_act--;
      model_free++;
    end
    // loop state still in between, no poll yet
    @(negedge clk);
    if (ext_cpu_q !== 1'b0) begin
      report_mismatch("ext_cpu_q one cycle after message", 32'(ext_cpu_q), 32'd0);
    end
  endtask

  task automatic forward_access(logic is_write, dispatch_pkg::addr_t addr,
                                dispatch_pkg::data_t wdata, dispatch_pkg::data_t reply);
    mem_reply = reply;
    mem_wdata = wdata;
    @(posedge clk);
    #1;
    read_q  = !is_write;
    write_q = is_write;
    addr_in = addr;
    data_in = wdata;
    @(posedge clk);
    #1;
    read_q  = 1'b0;
    write_q = 1'b0;
    addr_in = '0;
    data_in = '0;
    // external strobe one cycle after the request
    @(negedge clk);
    if ({ext_read_q, ext_write_q} !== {!is_write, is_write}) begin
      report_mismatch("memory strobes", 32'({ext_read_q, ext_write_q}),
                      32'({!is_write, is_write}));
    end
    if (ext_mem_addr_out !== addr) begin
      report_mismatch("ext_mem_addr_out", ext_mem_addr_out, addr);
    end
    // a read puts no data on the bus
    if (ext_mem_data_out !== (is_write ? wdata : '0)) begin
      report_mismatch("ext_mem_data_out", ext_mem_data_out, is_write ? wdata : '0);
    end
    while (read_dn !== 1'b1 && write_dn !== 1'b1) @(negedge clk);
    if ({read_dn, write_dn} !== {!is_write, is_write}) begin
      report_mismatch("cpu done flags", 32'({read_dn, write_dn}), 32'({!is_write, is_write}));
    end
    if (addr_out !== addr) begin
      report_mismatch("addr_out", addr_out, addr);
    end
    if (data_out !== (is_write ? wdata : reply)) begin
      report_mismatch("data_out", data_out, is_write ? wdata : reply);
    end
    // reply lasts a single cycle and then the bus is zero
    @(negedge clk);
    if ({read_dn, write_dn} !== 2'b00 || addr_out !== '0 || data_out !== '0) begin
      report_mismatch("cpu reply after done cycle", 32'({read_dn, write_dn}), 32'd0);
    end
  endtask

  // memory model, answers each strobe after 1 to 4 cycles
  initial begin : answer_memory
    dispatch_pkg::addr_t req_addr;
    logic                req_rd;
    int                  lat;
    ext_read_dn     = 1'b0;
    ext_write_dn    = 1'b0;
    ext_mem_addr_in = '0;
    ext_mem_data_in = '0;
    forever begin
      @(negedge clk);
      if (ext_read_q === 1'b1 || ext_write_q === 1'b1) begin
        req_addr = ext_mem_addr_out;
        req_rd   = ext_read_q;
        lat      = 1 + ($unsigned($random(seed)) % 4);
        repeat (lat) @(posedge clk);
        #1;
        ext_read_dn     = req_rd;
        ext_write_dn    = !req_rd;
        ext_mem_addr_in = req_addr;
        ext_mem_data_in = req_rd ? mem_reply : mem_wdata;
        @(posedge clk);
        #1;
        ext_read_dn     = 1'b0;
        ext_write_dn    = 1'b0;
        ext_mem_addr_in = '0;
        ext_mem_data_in = '0;
      end
    end
  end

  initial begin : watchdog
    wait (cases_loaded === 1'b1);
    repeat (n_cases * 40 + 200) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", n_cases * 40 + 200);
    $display(">>> FAIL");
    $finish;
  end

  initial begin : run_cases
    int i;
    rst        = 1'b1;
    read_q     = 1'b0;
    write_q    = 1'b0;
    ext_cpu_e  = 1'b0;
    ext_rst_e  = 1'b0;
    addr_in    = '0;
    data_in    = '0;
    cpu_msg_in = `MSG_NONE;
    mem_reply  = '0;
    mem_wdata  = '0;
    n_value_err = 0;
    n_other_err = 0;
    model_act       = 0;
    model_free      = `DISP_CPU_COUNT;
    model_cur       = 0;
    model_restarted = 1'b0;
    load_cases();
    cases_loaded = 1'b1;
    run_reset_wait();
    for (i = 0; i < n_cases; i++) begin
      check_next_poll();
      if (case_kind[i] == "R") begin
        forward_access(1'b0, case_addr[i], case_wdata[i], case_reply[i]);
      end else if (case_kind[i] == "W") begin
        forward_access(1'b1, case_addr[i], case_wdata[i], case_reply[i]);
      end else if (case_kind[i] == "S") begin
        send_message(`MSG_START);
      end else if (case_kind[i] == "E") begin
        send_message(`MSG_END);
      end else begin
        report_problem($sformatf("unknown case kind %s in case %0d", case_kind[i], i));
        // release the polled cpu without changing the pool
        send_message(`MSG_NONE);
      end
    end
    // one more poll after the last case
    check_next_poll();
    $display("errors: %0d value mismatches, %0d other problems", n_value_err, n_other_err);
    if (n_value_err == 0 && n_other_err == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+verilog
verilog/dispatch_pkg.sv
verilog/dispatch_ctl.sv
verilog/cpu_pool.sv
verilog/mem_bridge.sv
verilog/cpu_dispatcher.sv
tb/dispatch_props.sv
tb/tb_cpu_dispatcher.sv

//--- run_sim.sh
#!/bin/sh
# build with verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_cpu_dispatcher -f src.f -o tb_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "^>>> PASS$" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- tb/dispatch_cases.txt
# kind addr wdata reply, all hex, reads carry junk wdata that must not reach memory
# R read, W write, S start message, E end message
R 00001000 11110000 a5a50001
W 00001004 12345678 00000000
S 00000000 00000000 00000000
R 00002000 00000000 0badf00d
S 00000000 00000000 00000000
W 00002008 deadbeef 00000000
S 00000000 00000000 00000000
R 00003010 77777777 13572468
W 0000301c 89abcdef 00000000
E 00000000 00000000 00000000
R 00004000 00000000 feedface
E 00000000 00000000 00000000
W 00004444 55aa55aa 00000000
E 00000000 00000000 00000000
E 00000000 00000000 00000000
R 00005000 0f0f0f0f 00c0ffee
